/* logic/decode_pkg.sv */
package decode_pkg;

    // datapath and register file
    localparam int XLEN      = 32;
    localparam int GPR_NUM   = 32;
    localparam int GPR_AW    = 5;
    localparam int ALU_OP_W  = 8;
    localparam int ALU_SEL_W = 3;

    // flow control depths
    localparam int DECODE_DEPTH     = 2;
    localparam int DISPATCH_CREDITS = 2;
    localparam int QPTR_W           = $clog2(DECODE_DEPTH);
    localparam int DISP_CNT_W       = $clog2(DISPATCH_CREDITS + 1);

    // 3R opcodes, instr[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 opcodes, instr[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 1RI20 opcodes, instr[31:25]
    localparam logic [6:0] OP_LU12I_W   = 7'b0001010;
    localparam logic [6:0] OP_PCADDU12I = 7'b0001110;

    // 2RI16 opcodes, instr[31:26]
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;

    // ALU operations
    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 8'h01;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 8'h02;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 8'h03;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 8'h04;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 8'h05;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 8'h06;
    localparam logic [ALU_OP_W-1:0] ALU_LUI   = 8'h07;
    localparam logic [ALU_OP_W-1:0] ALU_PCADD = 8'h08;
    localparam logic [ALU_OP_W-1:0] ALU_LOAD  = 8'h09;
    localparam logic [ALU_OP_W-1:0] ALU_STORE = 8'h0a;
    localparam logic [ALU_OP_W-1:0] ALU_BEQ   = 8'h0b;
    localparam logic [ALU_OP_W-1:0] ALU_BNE   = 8'h0c;
    localparam logic [ALU_OP_W-1:0] ALU_JIRL  = 8'h0d;

    // result classes
    localparam logic [ALU_SEL_W-1:0] SEL_NONE  = 3'd0;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'd1;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'd2;
    localparam logic [ALU_SEL_W-1:0] SEL_MOVE  = 3'd3;
    localparam logic [ALU_SEL_W-1:0] SEL_MEM   = 3'd4;
    localparam logic [ALU_SEL_W-1:0] SEL_JUMP  = 3'd5;

    typedef struct packed {
        logic [16:0]       opcode;
        logic [GPR_AW-1:0] rk;
        logic [GPR_AW-1:0] rj;
        logic [GPR_AW-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]        opcode;
        logic [11:0]       imm12;
        logic [GPR_AW-1:0] rj;
        logic [GPR_AW-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]        opcode;
        logic [19:0]       imm20;
        logic [GPR_AW-1:0] rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [15:0]       offs16;
        logic [GPR_AW-1:0] rj;
        logic [GPR_AW-1:0] rd;
    } fmt_2ri16_t;

    // one instruction word, four field layouts
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_2ri16_t fmt_2ri16;
    } instr_word_u;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_word_u     instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic                 valid;
        // bit 1 is rj, bit 0 is rk
        logic [1:0]           reg_read_valid;
        logic [GPR_AW-1:0]    rj;
        logic [GPR_AW-1:0]    rk;
        logic                 use_imm;
        logic [XLEN-1:0]      imm;
        logic                 reg_write_valid;
        logic [GPR_AW-1:0]    rd;
        logic [ALU_OP_W-1:0]  aluop;
        logic [ALU_SEL_W-1:0] alusel;
    } dec_result_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        dec_result_t     result;
    } dec_out_t;

endpackage

/* logic/decoder_3r.sv */
`timescale 1ns/10ps

// register-register ALU ops, {opcode[17], rk, rj, rd}
module decoder_3r (
    input  decode_pkg::instr_word_u instr_i,
    output decode_pkg::dec_result_t result_o
);

    always_comb begin
        result_o = '0;
        result_o.valid           = 1'b1;
        result_o.reg_read_valid  = 2'b11;
        result_o.rj              = instr_i.fmt_3r.rj;
        result_o.rk              = instr_i.fmt_3r.rk;
        result_o.use_imm         = 1'b0;
        result_o.reg_write_valid = 1'b1;
        result_o.rd              = instr_i.fmt_3r.rd;
        case (instr_i.fmt_3r.opcode)
            decode_pkg::OP_ADD_W: begin
                result_o.aluop  = decode_pkg::ALU_ADD;
                result_o.alusel = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OP_SUB_W: begin
                result_o.aluop  = decode_pkg::ALU_SUB;
                result_o.alusel = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OP_AND: begin
                result_o.aluop  = decode_pkg::ALU_AND;
                result_o.alusel = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OP_OR: begin
                result_o.aluop  = decode_pkg::ALU_OR;
                result_o.alusel = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OP_XOR: begin
                result_o.aluop  = decode_pkg::ALU_XOR;
                result_o.alusel = decode_pkg::SEL_LOGIC;
            end
            default: begin
                // not a 3R word
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/decoder_2ri12.sv */
`timescale 1ns/10ps

// {opcode[10], imm12, rj, rd}
// arithmetic and memory ops sign-extend, logic ops zero-extend
module decoder_2ri12 (
    input  decode_pkg::instr_word_u instr_i,
    output decode_pkg::dec_result_t result_o
);

    logic [decode_pkg::XLEN-1:0] imm_sext;
    logic [decode_pkg::XLEN-1:0] imm_zext;

    assign imm_sext = {{20{instr_i.fmt_2ri12.imm12[11]}}, instr_i.fmt_2ri12.imm12};
    assign imm_zext = {20'b0, instr_i.fmt_2ri12.imm12};

    always_comb begin
        result_o = '0;
        result_o.valid           = 1'b1;
        result_o.reg_read_valid  = 2'b10;
        result_o.rj              = instr_i.fmt_2ri12.rj;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_sext;
        result_o.reg_write_valid = 1'b1;
        result_o.rd              = instr_i.fmt_2ri12.rd;
        case (instr_i.fmt_2ri12.opcode)
            decode_pkg::OP_ADDI_W: begin
                result_o.aluop  = decode_pkg::ALU_ADD;
                result_o.alusel = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OP_SLTI: begin
                result_o.aluop  = decode_pkg::ALU_SLT;
                result_o.alusel = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OP_ANDI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = decode_pkg::ALU_AND;
                result_o.alusel = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OP_ORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = decode_pkg::ALU_OR;
                result_o.alusel = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OP_LD_W: begin
                result_o.aluop  = decode_pkg::ALU_LOAD;
                result_o.alusel = decode_pkg::SEL_MEM;
            end
            decode_pkg::OP_ST_W: begin
                // store data comes from rd, carried in the rk slot
                result_o.reg_read_valid  = 2'b11;
                result_o.rk              = instr_i.fmt_2ri12.rd;
                result_o.reg_write_valid = 1'b0;
                result_o.rd              = '0;
                result_o.aluop           = decode_pkg::ALU_STORE;
                result_o.alusel          = decode_pkg::SEL_MEM;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/decoder_1ri20.sv */
`timescale 1ns/10ps

// {opcode[7], imm20, rd}
// LU12I.W and PCADDU12I, no register sources
module decoder_1ri20 (
    input  decode_pkg::instr_word_u instr_i,
    output decode_pkg::dec_result_t result_o
);

    logic [decode_pkg::XLEN-1:0] imm_hi;

    // imm20 lands in the upper bits
    assign imm_hi = {instr_i.fmt_1ri20.imm20, 12'b0};

    always_comb begin
        result_o = '0;
        result_o.valid           = 1'b1;
        result_o.reg_read_valid  = 2'b00;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_hi;
        result_o.reg_write_valid = 1'b1;
        result_o.rd              = instr_i.fmt_1ri20.rd;
        result_o.alusel          = decode_pkg::SEL_MOVE;
        case (instr_i.fmt_1ri20.opcode)
            decode_pkg::OP_LU12I_W: begin
                result_o.aluop = decode_pkg::ALU_LUI;
            end
            decode_pkg::OP_PCADDU12I: begin
                // adds to pc later in the pipe
                result_o.aluop = decode_pkg::ALU_PCADD;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/decoder_2ri16.sv */
`timescale 1ns/10ps

// {opcode[6], offs16, rj, rd}
// conditional branches and JIRL
module decoder_2ri16 (
    input  decode_pkg::instr_word_u instr_i,
    output decode_pkg::dec_result_t result_o
);

    logic [decode_pkg::XLEN-1:0] offs_ext;

    // word offset, shifted to bytes then sign-extended
    assign offs_ext = {{14{instr_i.fmt_2ri16.offs16[15]}}, instr_i.fmt_2ri16.offs16, 2'b00};

    always_comb begin
        result_o = '0;
        result_o.valid   = 1'b1;
        result_o.rj      = instr_i.fmt_2ri16.rj;
        result_o.use_imm = 1'b1;
        result_o.imm     = offs_ext;
        case (instr_i.fmt_2ri16.opcode)
            decode_pkg::OP_BEQ: begin
                // compare rj with rd, rd goes in the rk slot
                result_o.reg_read_valid = 2'b11;
                result_o.rk             = instr_i.fmt_2ri16.rd;
                result_o.aluop          = decode_pkg::ALU_BEQ;
                result_o.alusel         = decode_pkg::SEL_NONE;
            end
            decode_pkg::OP_BNE: begin
                result_o.reg_read_valid = 2'b11;
                result_o.rk             = instr_i.fmt_2ri16.rd;
                result_o.aluop          = decode_pkg::ALU_BNE;
                result_o.alusel         = decode_pkg::SEL_NONE;
            end
            decode_pkg::OP_JIRL: begin
                // link address goes to rd
                result_o.reg_read_valid  = 2'b10;
                result_o.reg_write_valid = 1'b1;
                result_o.rd              = instr_i.fmt_2ri16.rd;
                result_o.aluop           = decode_pkg::ALU_JIRL;
                result_o.alusel          = decode_pkg::SEL_JUMP;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/decode_ctrl.sv */
`timescale 1ns/10ps

module decode_ctrl (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    fetch_valid_i,
    input  decode_pkg::fetch_pkt_t  fetch_pkt_i,
    input  decode_pkg::dec_result_t res_3r_i,
    input  decode_pkg::dec_result_t res_2ri12_i,
    input  decode_pkg::dec_result_t res_1ri20_i,
    input  decode_pkg::dec_result_t res_2ri16_i,
    input  logic                    dispatch_credit_i,
    output decode_pkg::instr_word_u instr_o,
    output logic                    fetch_credit_o,
    output logic                    dec_valid_o,
    output decode_pkg::dec_out_t    dec_out_o
);

    logic                              in_valid_q;
    decode_pkg::fetch_pkt_t            in_pkt_q;
    logic [3:0]                        res_sel;
    decode_pkg::dec_result_t           res_pick;
    decode_pkg::dec_out_t              queue_q [decode_pkg::DECODE_DEPTH];
    logic [decode_pkg::QPTR_W:0]       wr_ptr_q;
    logic [decode_pkg::QPTR_W:0]       rd_ptr_q;
    logic                              q_empty;
    logic                              send;
    logic [decode_pkg::DISP_CNT_W-1:0] credit_q;

    // input register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            in_pkt_q <= fetch_pkt_i;
        end
    end

    assign instr_o = in_pkt_q.instr;

    // at most one decoder claims the word
    assign res_sel = {res_2ri16_i.valid, res_1ri20_i.valid, res_2ri12_i.valid, res_3r_i.valid};

    always_comb begin
        case (res_sel)
            4'b0001: res_pick = res_3r_i;
            4'b0010: res_pick = res_2ri12_i;
            4'b0100: res_pick = res_1ri20_i;
            4'b1000: res_pick = res_2ri16_i;
            default: res_pick = '0;
        endcase
    end

    // output queue, extra pointer bit tells full from empty
    assign q_empty = (wr_ptr_q == rd_ptr_q);
    assign send    = !q_empty && (credit_q != '0);

    always_ff @(posedge clk) begin
        if (in_valid_q) begin
            queue_q[wr_ptr_q[decode_pkg::QPTR_W-1:0]] <= '{pc: in_pkt_q.pc, result: res_pick};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (in_valid_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // dispatch credits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= decode_pkg::DISP_CNT_W'(decode_pkg::DISPATCH_CREDITS);
        end else begin
            case ({send, dispatch_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // registered outputs, fetch credit goes back with the result
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o    <= 1'b0;
            fetch_credit_o <= 1'b0;
        end else begin
            dec_valid_o    <= send;
            fetch_credit_o <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            dec_out_o <= queue_q[rd_ptr_q[decode_pkg::QPTR_W-1:0]];
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   fetch_valid_i,
    input  decode_pkg::fetch_pkt_t fetch_pkt_i,
    output logic                   fetch_credit_o,
    output logic                   dec_valid_o,
    output decode_pkg::dec_out_t   dec_out_o,
    input  logic                   dispatch_credit_i
);

    decode_pkg::instr_word_u instr;
    decode_pkg::dec_result_t res_3r;
    decode_pkg::dec_result_t res_2ri12;
    decode_pkg::dec_result_t res_1ri20;
    decode_pkg::dec_result_t res_2ri16;

    // all four formats look at the same registered word
    decoder_3r    u_dec_3r    (.instr_i(instr), .result_o(res_3r));
    decoder_2ri12 u_dec_2ri12 (.instr_i(instr), .result_o(res_2ri12));
    decoder_1ri20 u_dec_1ri20 (.instr_i(instr), .result_o(res_1ri20));
    decoder_2ri16 u_dec_2ri16 (.instr_i(instr), .result_o(res_2ri16));

    decode_ctrl u_ctrl (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_pkt_i       (fetch_pkt_i),
        .res_3r_i          (res_3r),
        .res_2ri12_i       (res_2ri12),
        .res_1ri20_i       (res_1ri20),
        .res_2ri16_i       (res_2ri16),
        .dispatch_credit_i (dispatch_credit_i),
        .instr_o           (instr),
        .fetch_credit_o    (fetch_credit_o),
        .dec_valid_o       (dec_valid_o),
        .dec_out_o         (dec_out_o)
    );

endmodule

/* bench/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] lfsr_state = 32'h5c9e281f;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

// expected decode, straight from the field layouts of each format
function automatic decode_pkg::dec_out_t decode_ref(input decode_pkg::fetch_pkt_t pkt);
    logic [31:0]             w;
    decode_pkg::dec_result_t r;
    decode_pkg::dec_out_t    o;
    int                      fmt;
    logic [7:0]              op;
    logic [2:0]              sel;
    logic                    zext;
    w = pkt.instr;
    r = '0;
    fmt = 0;
    op = '0;
    sel = '0;
    zext = 1'b0;
    case (w[31:15])
        17'h00020: begin fmt = 1; op = 8'h01; sel = 3'd2; end
        17'h00022: begin fmt = 1; op = 8'h02; sel = 3'd2; end
        17'h00029: begin fmt = 1; op = 8'h03; sel = 3'd1; end
        17'h0002a: begin fmt = 1; op = 8'h04; sel = 3'd1; end
        17'h0002b: begin fmt = 1; op = 8'h05; sel = 3'd1; end
        default: ;
    endcase
    case (w[31:22])
        10'h00a: begin fmt = 2; op = 8'h01; sel = 3'd2; end
        10'h008: begin fmt = 2; op = 8'h06; sel = 3'd2; end
        10'h00d: begin fmt = 2; op = 8'h03; sel = 3'd1; zext = 1'b1; end
        10'h00e: begin fmt = 2; op = 8'h04; sel = 3'd1; zext = 1'b1; end
        10'h0a2: begin fmt = 2; op = 8'h09; sel = 3'd4; end
        10'h0a6: begin fmt = 5; op = 8'h0a; sel = 3'd4; end
        default: ;
    endcase
    if (w[31:25] == 7'b0001010) begin fmt = 3; op = 8'h07; sel = 3'd3; end
    if (w[31:25] == 7'b0001110) begin fmt = 3; op = 8'h08; sel = 3'd3; end
    if (w[31:26] == 6'b010110) begin fmt = 4; op = 8'h0b; sel = 3'd0; end
    if (w[31:26] == 6'b010111) begin fmt = 4; op = 8'h0c; sel = 3'd0; end
    if (w[31:26] == 6'b010011) begin fmt = 6; op = 8'h0d; sel = 3'd5; end
    if (fmt != 0) begin
        r.valid  = 1'b1;
        r.aluop  = op;
        r.alusel = sel;
    end
    case (fmt)
        1: begin
            r.reg_read_valid = 2'b11;
            r.rj = w[9:5];
            r.rk = w[14:10];
            r.reg_write_valid = 1'b1;
            r.rd = w[4:0];
        end
        2, 5: begin
            r.rj = w[9:5];
            r.use_imm = 1'b1;
            r.imm = zext ? {20'b0, w[21:10]} : {{20{w[21]}}, w[21:10]};
            // store reads rd as data and writes nothing
            r.reg_read_valid = (fmt == 5) ? 2'b11 : 2'b10;
            r.rk = (fmt == 5) ? w[4:0] : 5'd0;
            r.reg_write_valid = (fmt != 5);
            r.rd = (fmt == 5) ? 5'd0 : w[4:0];
        end
        3: begin
            r.use_imm = 1'b1;
            r.imm = {w[24:5], 12'b0};
            r.reg_write_valid = 1'b1;
            r.rd = w[4:0];
        end
        4, 6: begin
            r.rj = w[9:5];
            r.use_imm = 1'b1;
            r.imm = {{14{w[25]}}, w[25:10], 2'b00};
            r.reg_read_valid = (fmt == 4) ? 2'b11 : 2'b10;
            r.rk = (fmt == 4) ? w[4:0] : 5'd0;
            r.reg_write_valid = (fmt == 6);
            r.rd = (fmt == 6) ? w[4:0] : 5'd0;
        end
        default: ;
    endcase
    o.pc = pkt.pc;
    o.result = r;
    return o;
endfunction

// random supported instruction, or an unsupported top opcode
task automatic gen_instr(output decode_pkg::fetch_pkt_t pkt, output string name);
    logic [31:0] w;
    int          sel;
    w = rand_bits(32);
    sel = rand_bits(5) % 18;
    case (sel)
        0: begin w[31:15] = 17'h00020; name = "add_w"; end
        1: begin w[31:15] = 17'h00022; name = "sub_w"; end
        2: begin w[31:15] = 17'h00029; name = "and"; end
        3: begin w[31:15] = 17'h0002a; name = "or"; end
        4: begin w[31:15] = 17'h0002b; name = "xor"; end
        5: begin w[31:22] = 10'h00a; name = "addi_w"; end
        6: begin w[31:22] = 10'h008; name = "slti"; end
        7: begin w[31:22] = 10'h00d; name = "andi"; end
        8: begin w[31:22] = 10'h00e; name = "ori"; end
        9: begin w[31:22] = 10'h0a2; name = "ld_w"; end
        10: begin w[31:22] = 10'h0a6; name = "st_w"; end
        11: begin w[31:25] = 7'b0001010; name = "lu12i_w"; end
        12: begin w[31:25] = 7'b0001110; name = "pcaddu12i"; end
        13: begin w[31:26] = 6'b010110; name = "beq"; end
        14: begin w[31:26] = 6'b010111; name = "bne"; end
        15: begin w[31:26] = 6'b010011; name = "jirl"; end
        default: begin w[31:25] = 7'b1111111; name = "unsupported"; end
    endcase
    pkt.pc = rand_bits(32);
    pkt.instr = w;
endtask

`endif

/* bench/decode_stage_tb.sv */
`timescale 1ns/10ps

module decode_stage_tb;

    localparam int N_RANDOM = 300;
    localparam int N_UNSUP  = 20;
    localparam int N_PRESS  = 200;
    localparam int N_TOTAL  = 1 + N_RANDOM + 10 + N_UNSUP + N_PRESS;
    localparam int LIMIT    = 8 * N_TOTAL + 100;

    logic                   clk;
    logic                   arst_n_i;
    logic                   fetch_valid_i;
    decode_pkg::fetch_pkt_t fetch_pkt_i;
    logic                   fetch_credit_o;
    logic                   dec_valid_o;
    decode_pkg::dec_out_t   dec_out_o;
    logic                   dispatch_credit_i;

    decode_pkg::dec_out_t exp_q[$];
    string                name_q[$];
    int cyc = 0;
    int value_errs = 0;
    int proto_errs = 0;
    int fetch_credits = decode_pkg::DECODE_DEPTH;
    int pending = 0;
    int returned = 0;
    int valid_cnt = 0;
    int stall_cnt = 0;
    bit press = 1'b0;
    bit lat_armed = 1'b0;
    int lat_cyc = 0;

    `include "decode_model.svh"

    decode_stage u_dut (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_pkt_i       (fetch_pkt_i),
        .fetch_credit_o    (fetch_credit_o),
        .dec_valid_o       (dec_valid_o),
        .dec_out_o         (dec_out_o),
        .dispatch_credit_i (dispatch_credit_i)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc++;
        if (cyc > LIMIT) begin
            $display("timeout after %0d cycles with %0d results missing", cyc, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // one drive step that also returns dispatch credits unless stalled
    task automatic drive_cycle(input logic valid, input decode_pkg::fetch_pkt_t pkt);
        @(posedge clk);
        #2;
        fetch_valid_i = valid;
        fetch_pkt_i = pkt;
        if (press && stall_cnt == 0 && rand_bits(2) == 0) begin
            stall_cnt = rand_bits(4);
        end
        if (pending > 0 && stall_cnt == 0) begin
            dispatch_credit_i = 1'b1;
            pending--;
        end else begin
            dispatch_credit_i = 1'b0;
        end
        if (stall_cnt > 0) begin
            stall_cnt--;
        end
    endtask

    task automatic send_pkt(input decode_pkg::fetch_pkt_t pkt, input string name);
        while (fetch_credits == 0) begin
            drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b1, pkt);
        fetch_credits--;
        exp_q.push_back(decode_ref(pkt));
        name_q.push_back(name);
    endtask

    task automatic send_word(input logic [31:0] w, input string name);
        decode_pkg::fetch_pkt_t pkt;
        pkt.pc = rand_bits(32);
        pkt.instr = w;
        send_pkt(pkt, name);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        decode_pkg::dec_out_t exp;
        string                name;
        if (arst_n_i) begin
            if (dispatch_credit_i) begin
                returned++;
            end
            if (dec_valid_o) begin
                valid_cnt++;
                pending++;
                assert (valid_cnt <= decode_pkg::DISPATCH_CREDITS + returned) else begin
                    $display("result sent without a dispatch credit at cycle %0d", cyc);
                    proto_errs++;
                end
                if (exp_q.size() == 0) begin
                    $display("extra result with nothing outstanding at cycle %0d", cyc);
                    proto_errs++;
                end else begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    assert (dec_out_o === exp) else begin
                        $display("ERR %s exp=%h act=%h", name, exp, dec_out_o);
                        value_errs++;
                    end
                end
                if (lat_armed) begin
                    lat_armed = 1'b0;
                    assert (cyc - lat_cyc == 2) else begin
                        $display("ERR latency exp=2 act=%0d", cyc - lat_cyc);
                        value_errs++;
                    end
                end
            end
            if (fetch_credit_o) begin
                assert (fetch_credits < decode_pkg::DECODE_DEPTH) else begin
                    $display("fetch credit returned with no instruction outstanding");
                    proto_errs++;
                end
                fetch_credits++;
            end
        end
    end

    initial begin
        decode_pkg::fetch_pkt_t pkt;
        string                  name;
        logic [24:0]            tail;
        clk = 1'b0;
        arst_n_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pkt_i = '0;
        dispatch_credit_i = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        assert (!dec_valid_o && !fetch_credit_o) else begin
            $display("outputs not low after reset");
            proto_errs++;
        end
        // latency on an idle stage, the word is taken two edges from now
        lat_armed = 1'b1;
        lat_cyc = cyc + 2;
        send_word({17'h00020, 5'd3, 5'd2, 5'd1}, "latency");
        for (int i = 0; i < N_RANDOM; i++) begin
            gen_instr(pkt, name);
            send_pkt(pkt, name);
        end
        // immediate extremes
        send_word({10'h00a, 12'hfff, 5'd31, 5'd31}, "imm_addi_sext");
        send_word({10'h008, 12'h800, 5'd1, 5'd2}, "imm_slti_sext");
        send_word({10'h00d, 12'hfff, 5'd3, 5'd4}, "imm_andi_zext");
        send_word({10'h00e, 12'h800, 5'd5, 5'd6}, "imm_ori_zext");
        send_word({7'b0001010, 20'hfffff, 5'd7}, "imm_lu12i_top");
        send_word({7'b0001110, 20'h80000, 5'd8}, "imm_pcaddu12i_top");
        send_word({6'b010110, 16'hffff, 5'd9, 5'd10}, "imm_beq_offs");
        send_word({6'b010111, 16'h8000, 5'd11, 5'd12}, "imm_bne_offs");
        send_word({6'b010011, 16'h8000, 5'd31, 5'd1}, "imm_jirl_offs");
        send_word({10'h0a6, 12'hfff, 5'd13, 5'd14}, "imm_st_sext");
        for (int i = 0; i < N_UNSUP; i++) begin
            tail = rand_bits(25);
            send_word({7'b1111111, tail}, "unsupported");
        end
        press = 1'b1;
        for (int i = 0; i < N_PRESS; i++) begin
            gen_instr(pkt, name);
            send_pkt(pkt, name);
        end
        press = 1'b0;
        while (exp_q.size() > 0 || pending > 0 || stall_cnt > 0) begin
            drive_cycle(1'b0, '0);
        end
        repeat (4) drive_cycle(1'b0, '0);
        assert (fetch_credits == decode_pkg::DECODE_DEPTH) else begin
            $display("buffer holds %0d credits after drain", fetch_credits);
            proto_errs++;
        end
        $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+bench
logic/decode_pkg.sv
logic/decoder_3r.sv
logic/decoder_2ri12.sv
logic/decoder_1ri20.sv
logic/decoder_2ri16.sv
logic/decode_ctrl.sv
logic/decode_stage.sv
bench/decode_stage_tb.sv
